// ==== src.f ====
source/ritc_pkg.sv
source/ritc_channel_storage.sv
source/ritc_input_storage.sv
source/ritc_trig_config.sv
source/ritc_window_trigger.sv
source/ritc_trigger_top.sv
testbench/ritc_tb.sv

// ==== testbench/ritc_tb.sv ====
module ritc_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int NB = ritc_pkg::NBITS;
	localparam int DX = ritc_pkg::DEMUX;
	localparam int SB = ritc_pkg::SAMPLE_BITS;
	// Depths handed to the DUT and used by the model
	localparam int A_ST = 0;
	localparam int B_ST = 2;
	localparam int C_ST = 3;
	// Test lengths in clocks
	localparam int T_HIST = 200;
	localparam int T_CFG = 100;
	localparam int T_TRIG = 300;
	localparam int T_PHASE = 300;
	localparam int TIMEOUT_CYCLES = 2 * (8 + T_HIST + T_CFG + T_TRIG + T_PHASE);
	// Mid-scale word that crosses neither reset threshold
	localparam logic [NB-1:0] IDLE_WORD = {DX{3'd3}};

	logic                               clk_i;
	logic                               rst_n_i;
	logic                               sync_i;
	logic [NB-1:0]                      a_i;
	logic [NB-1:0]                      b_i;
	logic [NB-1:0]                      c_i;
	logic                               cfg_we_i;
	ritc_pkg::reg_addr_e                cfg_addr_i;
	logic [ritc_pkg::CFG_BITS-1:0]      cfg_wdata_i;
	logic [ritc_pkg::CFG_BITS-1:0]      cfg_rdata_o;
	logic [NB*(A_ST+1)-1:0]             as_o;
	logic [NB*(B_ST+1)-1:0]             bs_o;
	logic [NB*(C_ST+1)-1:0]             cs_o;
	logic                               trig_o;
	logic [2:0]                         trig_hits_o;
	logic [ritc_pkg::PHASE_BITS-1:0]    trig_phase_o;

	// Model state
	// hist[ch][k] holds the word from k clocks back
	logic [NB-1:0]  hist [0:2][1:3];
	logic [2:0]     m_thr_hi;
	logic [2:0]     m_thr_lo;
	logic [2:0]     m_mask;
	logic [7:0]     m_status;
	logic [7:0]     m_phase;
	logic           exp_trig;
	logic [2:0]     exp_hits;
	logic [7:0]     exp_phase;
	logic [31:0]    seed;
	int             test_errs;
	int             total_errs;
	int             failed_tests;
	int             cycles;

	ritc_trigger_top #(
		.A_STAGES(A_ST), .B_STAGES(B_ST), .C_STAGES(C_ST)
	) dut0 (
		.clk_i(clk_i), .rst_n_i(rst_n_i), .sync_i(sync_i),
		.a_i(a_i), .b_i(b_i), .c_i(c_i),
		.cfg_we_i(cfg_we_i), .cfg_addr_i(cfg_addr_i), .cfg_wdata_i(cfg_wdata_i),
		.cfg_rdata_o(cfg_rdata_o), .as_o(as_o), .bs_o(bs_o), .cs_o(cs_o),
		.trig_o(trig_o), .trig_hits_o(trig_hits_o), .trig_phase_o(trig_phase_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #5 clk_i = ~clk_i;
	end

	// Hard stop in case a test stalls
	always @(posedge clk_i) begin
		cycles++;
		if (cycles > TIMEOUT_CYCLES) begin
			$display("Timeout: run exceeded %0d clock cycles", TIMEOUT_CYCLES);
			$display("TEST FAILED");
			$finish;
		end
	end

	//////////////////////////////
	// Random numbers
	//////////////////////////////

	function automatic logic [31:0] next_rand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	// Quiet words stay at 3 or 4 while loud words span the full range
	function automatic logic [NB-1:0] rand_word(input logic quiet);
		logic [NB-1:0] w;
		logic [31:0]   r;
		for (int i = 0; i < DX; i++) begin
			r = next_rand();
			w[i*SB +: SB] = quiet ? (3'd3 + {2'b00, r[16]}) : r[18:16];
		end
		return w;
	endfunction

	//////////////////////////////
	// Reference model
	//////////////////////////////

	function automatic int stages_of(input int ch);
		case (ch)
			0:       return A_ST;
			1:       return B_ST;
			default: return C_ST;
		endcase
	endfunction

	// Slot 0 is the word on the input right now
	function automatic logic [NB-1:0] slot_word(input int ch, input int k);
		if (k == 0) begin
			case (ch)
				0:       return a_i;
				1:       return b_i;
				default: return c_i;
			endcase
		end
		return hist[ch][k];
	endfunction

	function automatic logic [NB-1:0] port_slot(input int ch, input int k);
		case (ch)
			0:       return as_o[NB*k +: NB];
			1:       return bs_o[NB*k +: NB];
			default: return cs_o[NB*k +: NB];
		endcase
	endfunction

	function automatic string window_name(input int ch);
		case (ch)
			0:       return "as_o";
			1:       return "bs_o";
			default: return "cs_o";
		endcase
	endfunction

	// At or above the high threshold, or at or below the low one
	function automatic logic chan_hit(input int ch);
		logic [NB-1:0] w;
		logic [2:0]    s;
		logic          hit;
		hit = 1'b0;
		for (int k = 0; k <= stages_of(ch); k++) begin
			w = slot_word(ch, k);
			for (int i = 0; i < DX; i++) begin
				s = w[i*SB +: SB];
				if (s >= m_thr_hi || s <= m_thr_lo)
					hit = 1'b1;
			end
		end
		return hit;
	endfunction

	function automatic logic [7:0] exp_rdata();
		case (cfg_addr_i)
			ritc_pkg::REG_THR_HI: return {5'd0, m_thr_hi};
			ritc_pkg::REG_THR_LO: return {5'd0, m_thr_lo};
			ritc_pkg::REG_MASK:   return {5'd0, m_mask};
			default:              return m_status;
		endcase
	endfunction

	task automatic reset_model();
		for (int ch = 0; ch < 3; ch++)
			for (int k = 1; k <= 3; k++)
				hist[ch][k] = '0;
		m_thr_hi = 3'd7;
		m_thr_lo = 3'd0;
		m_mask = 3'b111;
		m_status = 8'd0;
		m_phase = 8'd0;
		exp_trig = 1'b0;
		exp_hits = 3'b000;
		exp_phase = 8'd0;
	endtask

	// Everything the DUT does on one rising edge using the old values
	task automatic model_edge();
		if (exp_trig)
			m_status = m_status + 8'd1;
		exp_hits = {chan_hit(2), chan_hit(1), chan_hit(0)};
		// No channel selected means no trigger
		exp_trig = (m_mask != 3'b000);
		for (int ch = 0; ch < 3; ch++)
			if (m_mask[ch] && !exp_hits[ch])
				exp_trig = 1'b0;
		exp_phase = m_phase;
		m_phase = sync_i ? 8'd0 : m_phase + 8'd1;
		if (cfg_we_i) begin
			case (cfg_addr_i)
				ritc_pkg::REG_THR_HI: m_thr_hi = cfg_wdata_i[2:0];
				ritc_pkg::REG_THR_LO: m_thr_lo = cfg_wdata_i[2:0];
				ritc_pkg::REG_MASK:   m_mask = cfg_wdata_i[2:0];
				default: ;
			endcase
		end
		for (int ch = 0; ch < 3; ch++) begin
			for (int k = 3; k >= 2; k--)
				hist[ch][k] = hist[ch][k-1];
			hist[ch][1] = slot_word(ch, 0);
		end
	endtask

	//////////////////////////////
	// Checks and stimulus
	//////////////////////////////

	task automatic compare(input string sig, input logic [63:0] got, input logic [63:0] exp);
		assert (got === exp) else begin
			$display("Error: %s = 0x%0h, expected 0x%0h", sig, got, exp);
			test_errs++;
		end
	endtask

	task automatic check_outputs();
		compare("trig_o", trig_o, exp_trig);
		compare("trig_hits_o", trig_hits_o, exp_hits);
		compare("trig_phase_o", trig_phase_o, exp_phase);
		compare("cfg_rdata_o", cfg_rdata_o, exp_rdata());
		for (int ch = 0; ch < 3; ch++)
			for (int k = 0; k <= stages_of(ch); k++)
				compare($sformatf("%s slot %0d", window_name(ch), k), port_slot(ch, k),
					slot_word(ch, k));
	endtask

	// Mode 0 reads only, 1 writes often, 2 writes now and then, 3 reads status
	task automatic drive_inputs(input int mode);
		logic [31:0] r;
		r = next_rand();
		sync_i = (r[31:16] % 20) == 0;
		r = next_rand();
		a_i = rand_word(r[17:16] != 2'b00);
		b_i = rand_word(r[19:18] != 2'b00);
		c_i = rand_word(r[21:20] != 2'b00);
		r = next_rand();
		cfg_addr_i = ritc_pkg::reg_addr_e'(r[17:16]);
		cfg_wdata_i = r[31:24];
		case (mode)
			0:       cfg_we_i = 1'b0;
			1:       cfg_we_i = r[20];
			2:       cfg_we_i = (r[22:21] == 2'b00);
			default: begin
				cfg_we_i = (r[23:20] == 4'd0);
				if (!cfg_we_i)
					cfg_addr_i = ritc_pkg::REG_STATUS;
			end
		endcase
	endtask

	task automatic run_test(input string name, input int mode, input int n);
		test_errs = 0;
		repeat (n) begin
			@(posedge clk_i);
			model_edge();
			#1;
			drive_inputs(mode);
			// All outputs have settled by mid-cycle
			#4;
			check_outputs();
		end
		report_test(name);
	endtask

	task automatic report_test(input string name);
		$display("%s: %s, %0d errors", name, (test_errs == 0) ? "passed" : "failed",
			test_errs);
		total_errs += test_errs;
		if (test_errs != 0)
			failed_tests++;
	endtask

	initial begin
		seed = 32'haa9c_0a46;
		cycles = 0;
		total_errs = 0;
		failed_tests = 0;
		rst_n_i = 1'b0;
		sync_i = 1'b0;
		a_i = IDLE_WORD;
		b_i = IDLE_WORD;
		c_i = IDLE_WORD;
		cfg_we_i = 1'b0;
		cfg_addr_i = ritc_pkg::REG_THR_HI;
		cfg_wdata_i = '0;
		repeat (8) @(posedge clk_i);
		#1;
		rst_n_i = 1'b1;
		reset_model();

		// Reset state with all four registers read inside one cycle
		test_errs = 0;
		for (int a = 0; a < 4; a++) begin
			cfg_addr_i = ritc_pkg::reg_addr_e'(a);
			#1;
			check_outputs();
		end
		report_test("reset state");

		run_test("history", 0, T_HIST);
		run_test("configuration", 1, T_CFG);
		run_test("trigger", 2, T_TRIG);
		run_test("phase and count", 3, T_PHASE);

		$display("Summary: 5 tests, %0d failed, %0d errors", failed_tests, total_errs);
		if (total_errs == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== source/ritc_trigger_top.sv ====
module ritc_trigger_top #(
	parameter int A_STAGES = 0,
	parameter int B_STAGES = 2,
	parameter int C_STAGES = 3
) (
	input  logic                                              clk_i,
	input  logic                                              rst_n_i,
	input  logic                                              sync_i,
	input  logic [ritc_pkg::NBITS-1:0]                        a_i,
	input  logic [ritc_pkg::NBITS-1:0]                        b_i,
	input  logic [ritc_pkg::NBITS-1:0]                        c_i,
	input  logic                                              cfg_we_i,
	input  ritc_pkg::reg_addr_e                               cfg_addr_i,
	input  logic [ritc_pkg::CFG_BITS-1:0]                     cfg_wdata_i,
	output logic [ritc_pkg::CFG_BITS-1:0]                     cfg_rdata_o,
	output logic [ritc_pkg::NBITS*(A_STAGES+1)-1:0]           as_o,
	output logic [ritc_pkg::NBITS*(B_STAGES+1)-1:0]           bs_o,
	output logic [ritc_pkg::NBITS*(C_STAGES+1)-1:0]           cs_o,
	output logic                                              trig_o,
	output logic [ritc_pkg::NCHAN-1:0]                        trig_hits_o,
	output logic [ritc_pkg::PHASE_BITS-1:0]                   trig_phase_o
);

	logic [ritc_pkg::DEMUX*(C_STAGES+1)-1:0]  csync;
	logic [ritc_pkg::SAMPLE_BITS-1:0]         thr_hi;
	logic [ritc_pkg::SAMPLE_BITS-1:0]         thr_lo;
	logic [ritc_pkg::NCHAN-1:0]               mask;

	// Windows go out as well as into the trigger
	// A and B sync flags are not needed by this trigger
	ritc_input_storage #(
		.A_STAGES(A_STAGES), .B_STAGES(B_STAGES), .C_STAGES(C_STAGES)
	) u_storage (
		.clk_i(clk_i), .rst_n_i(rst_n_i), .sync_i(sync_i),
		.a_i(a_i), .b_i(b_i), .c_i(c_i),
		.as_o(as_o), .bs_o(bs_o), .cs_o(cs_o),
		.async_o(), .bsync_o(), .csync_o(csync)
	);

	// Trigger output doubles as the count pulse
	ritc_trig_config u_config (
		.clk_i(clk_i), .rst_n_i(rst_n_i),
		.cfg_we_i(cfg_we_i), .cfg_addr_i(cfg_addr_i), .cfg_wdata_i(cfg_wdata_i),
		.trig_pulse_i(trig_o),
		.thr_hi_o(thr_hi), .thr_lo_o(thr_lo), .mask_o(mask),
		.cfg_rdata_o(cfg_rdata_o)
	);

	ritc_window_trigger #(
		.A_STAGES(A_STAGES), .B_STAGES(B_STAGES), .C_STAGES(C_STAGES)
	) u_trigger (
		.clk_i(clk_i), .rst_n_i(rst_n_i),
		.as_i(as_o), .bs_i(bs_o), .cs_i(cs_o), .csync_i(csync),
		.thr_hi_i(thr_hi), .thr_lo_i(thr_lo), .mask_i(mask),
		.trig_o(trig_o), .trig_hits_o(trig_hits_o), .trig_phase_o(trig_phase_o)
	);

endmodule

// ==== source/ritc_window_trigger.sv ====
module ritc_window_trigger #(
	parameter int A_STAGES = 0,
	parameter int B_STAGES = 2,
	parameter int C_STAGES = 3
) (
	input  logic                                              clk_i,
	input  logic                                              rst_n_i,
	input  logic [ritc_pkg::NBITS*(A_STAGES+1)-1:0]           as_i,
	input  logic [ritc_pkg::NBITS*(B_STAGES+1)-1:0]           bs_i,
	input  logic [ritc_pkg::NBITS*(C_STAGES+1)-1:0]           cs_i,
	input  logic [ritc_pkg::DEMUX*(C_STAGES+1)-1:0]           csync_i,
	input  logic [ritc_pkg::SAMPLE_BITS-1:0]                  thr_hi_i,
	input  logic [ritc_pkg::SAMPLE_BITS-1:0]                  thr_lo_i,
	input  logic [ritc_pkg::NCHAN-1:0]                        mask_i,
	output logic                                              trig_o,
	output logic [ritc_pkg::NCHAN-1:0]                        trig_hits_o,
	output logic [ritc_pkg::PHASE_BITS-1:0]                   trig_phase_o
);

	localparam int SB = ritc_pkg::SAMPLE_BITS;
	localparam int DX = ritc_pkg::DEMUX;
	// Widest window across the three channels
	localparam int AB_MAX = (A_STAGES > B_STAGES) ? A_STAGES : B_STAGES;
	localparam int MAX_STAGES = (C_STAGES > AB_MAX) ? C_STAGES : AB_MAX;
	localparam int MAX_SAMPLES = DX * (MAX_STAGES + 1);
	localparam int WIN_BITS = ritc_pkg::NBITS * (MAX_STAGES + 1);

	//////////////////////////////
	// Threshold hit detection
	//////////////////////////////

	// Scans the first nsamp samples of a zero-padded window
	// Padding is skipped, it would always pass the low threshold
	function automatic logic window_hit(
		input logic [WIN_BITS-1:0] win,
		input int                  nsamp,
		input logic [SB-1:0]       thr_hi,
		input logic [SB-1:0]       thr_lo
	);
		logic [SB-1:0] smp;
		logic          hit;
		hit = 1'b0;
		for (int i = 0; i < MAX_SAMPLES; i++) begin
			smp = win[i*SB +: SB];
			if ((i < nsamp) && ((smp >= thr_hi) || (smp <= thr_lo))) begin
				hit = 1'b1;
			end
		end
		return hit;
	endfunction

	logic [ritc_pkg::NCHAN-1:0] hits;

	// Bit 0 A, bit 1 B, bit 2 C
	always_comb begin
		hits[0] = window_hit(WIN_BITS'(as_i), DX * (A_STAGES + 1), thr_hi_i, thr_lo_i);
		hits[1] = window_hit(WIN_BITS'(bs_i), DX * (B_STAGES + 1), thr_hi_i, thr_lo_i);
		hits[2] = window_hit(WIN_BITS'(cs_i), DX * (C_STAGES + 1), thr_hi_i, thr_lo_i);
	end

	//////////////////////////////
	// Frame phase
	//////////////////////////////

	logic [ritc_pkg::PHASE_BITS-1:0] phase_q;

	// Restarts on the live sync flag of channel C
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			phase_q <= '0;
		end else if (csync_i[0]) begin
			phase_q <= '0;
		end else begin
			phase_q <= phase_q + 1'b1;
		end
	end

	//////////////////////////////
	// Coincidence output
	//////////////////////////////

	// Every masked channel must hit, an empty mask never fires
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			trig_o       <= 1'b0;
			trig_hits_o  <= '0;
			trig_phase_o <= '0;
		end else begin
			trig_o       <= (|mask_i) && ((hits & mask_i) == mask_i);
			trig_hits_o  <= hits;
			// Counter value before this edge's update
			trig_phase_o <= phase_q;
		end
	end

endmodule

// ==== source/ritc_trig_config.sv ====
module ritc_trig_config (
	input  logic                                clk_i,
	input  logic                                rst_n_i,
	input  logic                                cfg_we_i,
	input  ritc_pkg::reg_addr_e                 cfg_addr_i,
	input  logic [ritc_pkg::CFG_BITS-1:0]       cfg_wdata_i,
	input  logic                                trig_pulse_i,
	output logic [ritc_pkg::SAMPLE_BITS-1:0]    thr_hi_o,
	output logic [ritc_pkg::SAMPLE_BITS-1:0]    thr_lo_o,
	output logic [ritc_pkg::NCHAN-1:0]          mask_o,
	output logic [ritc_pkg::CFG_BITS-1:0]       cfg_rdata_o
);

	localparam int SB = ritc_pkg::SAMPLE_BITS;
	localparam int NC = ritc_pkg::NCHAN;

	logic [SB-1:0]                       thr_hi_q;
	logic [SB-1:0]                       thr_lo_q;
	logic [NC-1:0]                       mask_q;
	logic [ritc_pkg::STATUS_BITS-1:0]    status_q;

	//////////////////////////////
	// Control registers
	//////////////////////////////

	// Defaults let only full-scale samples fire, all channels required
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			thr_hi_q <= '1;
			thr_lo_q <= '0;
			mask_q   <= '1;
		end else if (cfg_we_i) begin
			case (cfg_addr_i)
				ritc_pkg::REG_THR_HI: thr_hi_q <= cfg_wdata_i[SB-1:0];
				ritc_pkg::REG_THR_LO: thr_lo_q <= cfg_wdata_i[SB-1:0];
				ritc_pkg::REG_MASK:   mask_q   <= cfg_wdata_i[NC-1:0];
				// Status is read only
				default: ;
			endcase
		end
	end

	// Trigger count, wraps at the top
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			status_q <= '0;
		end else if (trig_pulse_i) begin
			status_q <= status_q + 1'b1;
		end
	end

	assign thr_hi_o = thr_hi_q;
	assign thr_lo_o = thr_lo_q;
	assign mask_o   = mask_q;

	//////////////////////////////
	// Readback
	//////////////////////////////

	// Zero-extended onto the data bus
	always_comb begin
		cfg_rdata_o = '0;
		case (cfg_addr_i)
			ritc_pkg::REG_THR_HI: cfg_rdata_o[SB-1:0] = thr_hi_q;
			ritc_pkg::REG_THR_LO: cfg_rdata_o[SB-1:0] = thr_lo_q;
			ritc_pkg::REG_MASK:   cfg_rdata_o[NC-1:0] = mask_q;
			default:              cfg_rdata_o[ritc_pkg::STATUS_BITS-1:0] = status_q;
		endcase
	end

endmodule

// ==== source/ritc_input_storage.sv ====
module ritc_input_storage #(
	parameter int A_STAGES = 0,
	parameter int B_STAGES = 2,
	parameter int C_STAGES = 3
) (
	input  logic                                              clk_i,
	input  logic                                              rst_n_i,
	input  logic                                              sync_i,
	input  logic [ritc_pkg::NBITS-1:0]                        a_i,
	input  logic [ritc_pkg::NBITS-1:0]                        b_i,
	input  logic [ritc_pkg::NBITS-1:0]                        c_i,
	output logic [ritc_pkg::NBITS*(A_STAGES+1)-1:0]           as_o,
	output logic [ritc_pkg::NBITS*(B_STAGES+1)-1:0]           bs_o,
	output logic [ritc_pkg::NBITS*(C_STAGES+1)-1:0]           cs_o,
	output logic [ritc_pkg::DEMUX*(A_STAGES+1)-1:0]           async_o,
	output logic [ritc_pkg::DEMUX*(B_STAGES+1)-1:0]           bsync_o,
	output logic [ritc_pkg::DEMUX*(C_STAGES+1)-1:0]           csync_o
);

	localparam int DX = ritc_pkg::DEMUX;
	// Sync chain must cover the deepest channel
	localparam int AB_MAX = (A_STAGES > B_STAGES) ? A_STAGES : B_STAGES;
	localparam int MAX_STAGES = (C_STAGES > AB_MAX) ? C_STAGES : AB_MAX;

	//////////////////////////////
	// Sample histories
	//////////////////////////////

	ritc_channel_storage #(.STAGES(A_STAGES)) u_store_a (
		.clk_i(clk_i), .rst_n_i(rst_n_i), .in_i(a_i), .out_o(as_o)
	);
	ritc_channel_storage #(.STAGES(B_STAGES)) u_store_b (
		.clk_i(clk_i), .rst_n_i(rst_n_i), .in_i(b_i), .out_o(bs_o)
	);
	ritc_channel_storage #(.STAGES(C_STAGES)) u_store_c (
		.clk_i(clk_i), .rst_n_i(rst_n_i), .in_i(c_i), .out_o(cs_o)
	);

	//////////////////////////////
	// Shared sync delay chain
	//////////////////////////////

	// Tap k is sync_i from k clocks back
	logic [MAX_STAGES:0] sync_tap;

	generate
		if (MAX_STAGES == 0) begin : g_no_chain
			assign sync_tap = sync_i;
		end else begin : g_chain
			logic [MAX_STAGES-1:0] sync_q;

			assign sync_tap = {sync_q, sync_i};

			always_ff @(posedge clk_i) begin
				if (!rst_n_i) begin
					sync_q <= '0;
				end else begin
					sync_q <= sync_tap[MAX_STAGES-1:0];
				end
			end
		end
	endgenerate

	// Each stored sample gets its own copy of the word's sync flag
	generate
		for (genvar k = 0; k <= A_STAGES; k++) begin : g_async
			assign async_o[DX*k +: DX] = {DX{sync_tap[k]}};
		end
		for (genvar k = 0; k <= B_STAGES; k++) begin : g_bsync
			assign bsync_o[DX*k +: DX] = {DX{sync_tap[k]}};
		end
		for (genvar k = 0; k <= C_STAGES; k++) begin : g_csync
			assign csync_o[DX*k +: DX] = {DX{sync_tap[k]}};
		end
	endgenerate

endmodule

// ==== source/ritc_channel_storage.sv ====
module ritc_channel_storage #(
	parameter int STAGES = 0
) (
	input  logic                                   clk_i,
	input  logic                                   rst_n_i,
	input  logic [ritc_pkg::NBITS-1:0]             in_i,
	output logic [ritc_pkg::NBITS*(STAGES+1)-1:0]  out_o
);

	localparam int W = ritc_pkg::NBITS;

	generate
		if (STAGES == 0) begin : g_pass
			// No history kept, window is just the live word
			assign out_o = in_i;
		end else begin : g_hist
			// Slot k sits at [W*k +: W], slot 0 is the live input
			logic [W*STAGES-1:0] hist_q;

			// Newest first, live word in the low bits
			assign out_o = {hist_q, in_i};

			// Shift by one word per clock
			// Oldest word falls off the top
			always_ff @(posedge clk_i) begin
				if (!rst_n_i) begin
					hist_q <= '0;
				end else begin
					hist_q <= out_o[W*STAGES-1:0];
				end
			end
		end
	endgenerate

endmodule

// ==== source/ritc_pkg.sv ====
package ritc_pkg;

	//////////////////////////////
	// Sample geometry
	//////////////////////////////

	// Samples per clock per channel
	localparam int DEMUX = 16;
	// Offset binary, 0 to 7
	localparam int SAMPLE_BITS = 3;
	// One channel word holds a full clock of samples
	localparam int NBITS = DEMUX * SAMPLE_BITS;
	// Channels A, B and C
	localparam int NCHAN = 3;

	//////////////////////////////
	// Trigger and config widths
	//////////////////////////////

	// Frame phase counter
	localparam int PHASE_BITS = 8;
	// Config write and readback bus
	localparam int CFG_BITS = 8;
	// Trigger count, wraps
	localparam int STATUS_BITS = 8;

	// Config register map
	typedef enum logic [1:0] {
		REG_THR_HI = 2'd0,
		REG_THR_LO = 2'd1,
		REG_MASK   = 2'd2,
		REG_STATUS = 2'd3
	} reg_addr_e;

endpackage
